//--- source/video_pkg.sv
/*
  Raster constants for 720x480p at 858x525 total, one pixel per clock.
  Sync windows are half-open: start <= position < end.
  Sync polarity is active high at this level.
*/
package video_pkg;

    //////////////////////////////////////////////////////////////////////
    // Horizontal timing
    //////////////////////////////////////////////////////////////////////

    // 720 active + 16 front porch + 62 sync + 60 back porch
    localparam int H_ACTIVE     = 720;
    localparam int H_TOTAL      = 858;
    localparam int H_SYNC_START = 736;
    localparam int H_SYNC_END   = 798;

    //////////////////////////////////////////////////////////////////////
    // Vertical timing
    //////////////////////////////////////////////////////////////////////

    // 480 active + 9 front porch + 6 sync + 30 back porch
    localparam int V_ACTIVE     = 480;
    localparam int V_TOTAL      = 525;
    localparam int V_SYNC_START = 489;
    localparam int V_SYNC_END   = 495;

    //////////////////////////////////////////////////////////////////////
    // Coordinates
    //////////////////////////////////////////////////////////////////////

    // Raster x or y position, wide enough for both totals
    typedef logic [9:0] coord_t;

endpackage

//--- source/pixel_pkg.sv
/*
  Stored pixel format, RGB888 output type and line buffer geometry.
  COLOR_BITS must be 12, 15, 18 or 24; channels are packed R, G, B from the MSB.
  fb_width is a multiple of 4 in 4..720, fb_height is 1..240.
*/
package pixel_pkg;

    // Stored color depth, RGB666
    localparam int COLOR_BITS = 18;

    // Pixels per line buffer bank, 2**LB_ADDR_BITS
    localparam int LB_ADDR_BITS = 10;

    typedef logic [COLOR_BITS-1:0] color_t;
    typedef logic [23:0]           rgb_t;

    // Bank bit on top of the pixel index
    typedef logic [LB_ADDR_BITS:0] lb_addr_t;

    // Framebuffer size
    typedef logic [9:0] fb_width_t;
    typedef logic [8:0] fb_height_t;

    // Widen each channel to 8 bits, zeros appended below
    function automatic rgb_t to_rgb(input color_t c);
        logic [23:0] p;
        p = 24'(c);
        case (COLOR_BITS)
            12: to_rgb = {p[11:8], 4'b0, p[7:4], 4'b0, p[3:0], 4'b0};
            15: to_rgb = {p[14:10], 3'b0, p[9:5], 3'b0, p[4:0], 3'b0};
            18: to_rgb = {p[17:12], 2'b0, p[11:6], 2'b0, p[5:0], 2'b0};
            default: to_rgb = p;
        endcase
    endfunction

endpackage

//--- source/line_fill.sv
/*
  Turns the fill strobes into line buffer writes, one cycle after the strobe.
  fill_start selects bank fill_line[0] and restarts at pixel 0.
  No back-pressure; the source must not overrun the bank in use for display.
*/
`timescale 1ns/1ps

module line_fill (
    input  logic                clk_pixel,
    input  logic                reset,
    input  logic                fill_start,
    input  logic [8:0]          fill_line,
    input  logic                fill_we,
    input  pixel_pkg::color_t   fill_pixel,
    output logic                wr_en,
    output pixel_pkg::lb_addr_t wr_addr,
    output pixel_pkg::color_t   wr_data
);

    // Current bank and running pixel index
    logic                              bank;
    logic [pixel_pkg::LB_ADDR_BITS-1:0] index;

    // Effective bank and index, a start in the same cycle wins
    logic                              bank_sel;
    logic [pixel_pkg::LB_ADDR_BITS-1:0] index_sel;

    assign bank_sel  = fill_start ? fill_line[0] : bank;
    assign index_sel = fill_start ? '0 : index;

    // Control state
    always_ff @(posedge clk_pixel or posedge reset) begin
        if (reset) begin
            bank  <= 1'b0;
            index <= '0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= fill_we;
            bank  <= bank_sel;
            if (fill_we) begin
                index <= index_sel + 1'b1;
            end else begin
                index <= index_sel;
            end
        end
    end

    // Write payload, only meaningful with wr_en
    always_ff @(posedge clk_pixel) begin
        if (fill_we) begin
            wr_addr <= {bank_sel, index_sel};
            wr_data <= fill_pixel;
        end
    end

endmodule

//--- source/line_buffer.sv
/*
  Two-bank line memory, 2 x 1024 stored pixels.
  One synchronous write port, one read port with a registered output.
  Read and write to the same address in one cycle returns the old word.
*/
`timescale 1ns/1ps

module line_buffer (
    input  logic                clk_pixel,
    input  logic                wr_en,
    input  pixel_pkg::lb_addr_t wr_addr,
    input  pixel_pkg::color_t   wr_data,
    input  pixel_pkg::lb_addr_t rd_addr,
    output pixel_pkg::color_t   rd_data
);

    // Both banks in one array, bank bit is the address MSB
    localparam int DEPTH = 2 ** (pixel_pkg::LB_ADDR_BITS + 1);

    pixel_pkg::color_t mem [0:DEPTH-1];

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    // One cycle latency, address must lead the pixel by one clock
    always_ff @(posedge clk_pixel) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- source/raster_timing.sv
/*
  Free-running 858x525 raster counters, advancing every clock.
  hsync, vsync and de are combinational levels aligned with cx and cy.
  Both counters are 0 right after reset.
*/
`timescale 1ns/1ps

module raster_timing (
    input  logic              clk_pixel,
    input  logic              reset,
    output video_pkg::coord_t cx,
    output video_pkg::coord_t cy,
    output logic              hsync,
    output logic              vsync,
    output logic              de
);

    // Last position of a line and of a frame
    logic h_last;
    logic v_last;

    assign h_last = (cx == video_pkg::coord_t'(video_pkg::H_TOTAL - 1));
    assign v_last = (cy == video_pkg::coord_t'(video_pkg::V_TOTAL - 1));

    //////////////////////////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_pixel or posedge reset) begin
        if (reset) begin
            cx <= '0;
            cy <= '0;
        end else begin
            if (h_last) begin
                cx <= '0;
                // Line wrap steps the vertical counter
                if (v_last) begin
                    cy <= '0;
                end else begin
                    cy <= cy + 1'b1;
                end
            end else begin
                cx <= cx + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sync and display enable
    //////////////////////////////////////////////////////////////////////

    // Half-open sync windows
    assign hsync = (cx >= video_pkg::coord_t'(video_pkg::H_SYNC_START))
                && (cx <  video_pkg::coord_t'(video_pkg::H_SYNC_END));
    assign vsync = (cy >= video_pkg::coord_t'(video_pkg::V_SYNC_START))
                && (cy <  video_pkg::coord_t'(video_pkg::V_SYNC_END));

    // Top-left 720x480 is visible
    assign de = (cx < video_pkg::coord_t'(video_pkg::H_ACTIVE))
             && (cy < video_pkg::coord_t'(video_pkg::V_ACTIVE));

endmodule

//--- source/active_window.sv
/*
  Centers the framebuffer picture in 720x480 and addresses the line buffer.
  Border registers settle within two clocks of a size change.
  rd_addr leads cx by one pixel, including the wrap to the next line.
  Each framebuffer line spans two display lines; bank is its parity.
*/
`timescale 1ns/1ps

module active_window (
    input  logic                  clk_pixel,
    input  logic                  reset,
    input  video_pkg::coord_t     cx,
    input  video_pkg::coord_t     cy,
    input  pixel_pkg::fb_width_t  fb_width,
    input  pixel_pkg::fb_height_t fb_height,
    output pixel_pkg::lb_addr_t   rd_addr,
    output logic                  in_active
);

    // Border widths, then picture start and end
    video_pkg::coord_t h_border;
    video_pkg::coord_t v_border;
    video_pkg::coord_t h_start;
    video_pkg::coord_t h_end;
    video_pkg::coord_t v_start;
    video_pkg::coord_t v_end;

    // Position of the next pixel
    logic              h_wrap;
    video_pkg::coord_t next_x;
    video_pkg::coord_t next_y;
    logic              next_in_pic;

    // Next pixel relative to the picture origin
    video_pkg::coord_t pic_x;
    video_pkg::coord_t pic_y;
    logic [8:0]        fb_line;

    //////////////////////////////////////////////////////////////////////
    // Borders
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_pixel or posedge reset) begin
        if (reset) begin
            h_border <= '0;
            v_border <= '0;
            h_start  <= '0;
            h_end    <= '0;
            v_start  <= '0;
            v_end    <= '0;
        end else begin
            // Sizes are within range, so both differences are non-negative
            h_border <= video_pkg::coord_t'((video_pkg::H_ACTIVE - int'(fb_width)) / 2);
            v_border <= video_pkg::coord_t'((video_pkg::V_ACTIVE - 2 * int'(fb_height)) / 2);
            h_start  <= h_border;
            h_end    <= video_pkg::coord_t'(video_pkg::H_ACTIVE) - h_border;
            v_start  <= v_border;
            v_end    <= video_pkg::coord_t'(video_pkg::V_ACTIVE) - v_border;
        end
    end

    // Picture flag for the current pixel
    assign in_active = (cx >= h_start) && (cx < h_end)
                    && (cy >= v_start) && (cy < v_end);

    //////////////////////////////////////////////////////////////////////
    // Early read address
    //////////////////////////////////////////////////////////////////////

    // Mirror the raster counters one step ahead
    assign h_wrap = (cx == video_pkg::coord_t'(video_pkg::H_TOTAL - 1));
    assign next_x = h_wrap ? '0 : cx + 1'b1;

    always_comb begin
        if (!h_wrap) begin
            next_y = cy;
        end else if (cy == video_pkg::coord_t'(video_pkg::V_TOTAL - 1)) begin
            next_y = '0;
        end else begin
            next_y = cy + 1'b1;
        end
    end

    assign next_in_pic = (next_x >= h_start) && (next_x < h_end)
                      && (next_y >= v_start) && (next_y < v_end);

    assign pic_x   = next_x - h_start;
    assign pic_y   = next_y - v_start;
    // Two display lines per framebuffer line
    assign fb_line = pic_y[9:1];

    // Address 0 outside the picture
    assign rd_addr = next_in_pic ? {fb_line[0], pic_x[pixel_pkg::LB_ADDR_BITS-1:0]} : '0;

endmodule

//--- source/pixel_output.sv
/*
  Final pixel stage, one register between raster and outputs.
  Order: picture or border, odd-line dimming, sleep, then overlay.
  rgb is black outside the 720x480 visible area.
  rgb, coordinates and sync levels leave together, 0 after reset.
*/
`timescale 1ns/1ps

module pixel_output (
    input  logic              clk_pixel,
    input  logic              reset,
    input  video_pkg::coord_t cx,
    input  video_pkg::coord_t cy,
    input  logic              hsync_in,
    input  logic              vsync_in,
    input  logic              de_in,
    input  logic              in_active,
    input  pixel_pkg::color_t rd_data,
    input  pixel_pkg::color_t border_color,
    input  logic              sleep,
    input  logic              overlay_en,
    input  pixel_pkg::rgb_t   overlay_rgb,
    output pixel_pkg::rgb_t   rgb,
    output video_pkg::coord_t out_x,
    output video_pkg::coord_t out_y,
    output logic              de,
    output logic              hsync,
    output logic              vsync
);

    pixel_pkg::rgb_t base_rgb;
    pixel_pkg::rgb_t dim_rgb;
    pixel_pkg::rgb_t pixel_rgb;

    //////////////////////////////////////////////////////////////////////
    // Pixel rule
    //////////////////////////////////////////////////////////////////////

    // Line buffer word is aligned with cx here
    assign base_rgb = pixel_pkg::to_rgb(in_active ? rd_data : border_color);

    // Odd display lines at half brightness, per channel
    assign dim_rgb = cy[0] ?
        {1'b0, base_rgb[23:17], 1'b0, base_rgb[15:9], 1'b0, base_rgb[7:1]} :
        base_rgb;

    always_comb begin
        if (!de_in) begin
            pixel_rgb = '0;
        end else if (overlay_en) begin
            // Overlay wins over sleep and dimming
            pixel_rgb = overlay_rgb;
        end else if (sleep) begin
            pixel_rgb = '0;
        end else begin
            pixel_rgb = dim_rgb;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_pixel or posedge reset) begin
        if (reset) begin
            rgb   <= '0;
            out_x <= '0;
            out_y <= '0;
            de    <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end else begin
            rgb   <= pixel_rgb;
            out_x <= cx;
            out_y <= cy;
            de    <= de_in;
            hsync <= hsync_in;
            vsync <= vsync_in;
        end
    end

endmodule

//--- source/scan_doubler_480p.sv
/*
  480p scan doubler output, single clock domain clk_pixel.
  Framebuffer lines arrive through the fill strobes into a two-bank line buffer.
  Outputs lag the raster by one clock; rgb matches out_x and out_y.
*/
`timescale 1ns/1ps

module scan_doubler_480p (
    input  logic                  clk_pixel,
    input  logic                  reset,
    input  pixel_pkg::fb_width_t  fb_width,
    input  pixel_pkg::fb_height_t fb_height,
    input  pixel_pkg::color_t     border_color,
    input  logic                  sleep,
    input  logic                  overlay_en,
    input  pixel_pkg::rgb_t       overlay_rgb,
    input  logic                  fill_start,
    input  logic [8:0]            fill_line,
    input  logic                  fill_we,
    input  pixel_pkg::color_t     fill_pixel,
    output pixel_pkg::rgb_t       rgb,
    output video_pkg::coord_t     out_x,
    output video_pkg::coord_t     out_y,
    output logic                  de,
    output logic                  hsync,
    output logic                  vsync
);

    // Fill path
    logic                wr_en;
    pixel_pkg::lb_addr_t wr_addr;
    pixel_pkg::color_t   wr_data;

    // Raster and read path
    video_pkg::coord_t   cx;
    video_pkg::coord_t   cy;
    logic                raster_hsync;
    logic                raster_vsync;
    logic                raster_de;
    logic                in_active;
    pixel_pkg::lb_addr_t rd_addr;
    pixel_pkg::color_t   rd_data;

    //////////////////////////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////////////////////////

    line_fill i_line_fill (
        .clk_pixel  (clk_pixel),
        .reset      (reset),
        .fill_start (fill_start),
        .fill_line  (fill_line),
        .fill_we    (fill_we),
        .fill_pixel (fill_pixel),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data)
    );

    line_buffer i_line_buffer (
        .clk_pixel (clk_pixel),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Raster and picture window
    //////////////////////////////////////////////////////////////////////

    raster_timing i_raster_timing (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .cx        (cx),
        .cy        (cy),
        .hsync     (raster_hsync),
        .vsync     (raster_vsync),
        .de        (raster_de)
    );

    active_window i_active_window (
        .clk_pixel (clk_pixel),
        .reset     (reset),
        .cx        (cx),
        .cy        (cy),
        .fb_width  (fb_width),
        .fb_height (fb_height),
        .rd_addr   (rd_addr),
        .in_active (in_active)
    );

    //////////////////////////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////////////////////////

    pixel_output i_pixel_output (
        .clk_pixel    (clk_pixel),
        .reset        (reset),
        .cx           (cx),
        .cy           (cy),
        .hsync_in     (raster_hsync),
        .vsync_in     (raster_vsync),
        .de_in        (raster_de),
        .in_active    (in_active),
        .rd_data      (rd_data),
        .border_color (border_color),
        .sleep        (sleep),
        .overlay_en   (overlay_en),
        .overlay_rgb  (overlay_rgb),
        .rgb          (rgb),
        .out_x        (out_x),
        .out_y        (out_y),
        .de           (de),
        .hsync        (hsync),
        .vsync        (vsync)
    );

endmodule

//--- test/tb_clock.sv
/*
  Testbench clock of 4 ns period, starting low.
  Reset is high from time 0 for 8 rising edges, released on a falling edge.
*/
`timescale 1ns/1ps

module tb_clock (
    output logic clk_pixel,
    output logic reset
);

    // Half of the 4 ns period
    localparam int HALF_PERIOD = 2;

    initial begin
        clk_pixel = 1'b0;
        forever begin
            #(HALF_PERIOD);
            clk_pixel = ~clk_pixel;
        end
    end

    // Reset held for 8 cycles
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk_pixel);
        @(negedge clk_pixel);
        reset = 1'b0;
    end

endmodule

//--- test/tb_scan_doubler_480p.sv
/*
  Self-checking testbench for the 480p scan doubler.
  Each table row is applied in vertical blanking, then one whole frame is checked.
  Inputs change and outputs are sampled on falling edges of clk_pixel.
  With two banks, all framebuffer lines of one parity show the same data.
*/
`timescale 1ns/1ps

module tb_scan_doubler_480p;

    // One row of the stimulus table
    typedef struct packed {
        pixel_pkg::fb_width_t  width;
        pixel_pkg::fb_height_t height;
        pixel_pkg::color_t     border;
        logic                  sleep;
        logic                  overlay_en;
        pixel_pkg::rgb_t       overlay_rgb;
        logic                  refill;
    } row_t;

    localparam int NUM_ROWS     = 6;
    localparam int FRAME_CYCLES = video_pkg::H_TOTAL * video_pkg::V_TOTAL;
    localparam int WAIT_LIMIT   = FRAME_CYCLES + video_pkg::H_TOTAL;
    localparam int RESET_LIMIT  = 64;
    // Pixels loaded per bank for the widest picture
    localparam int FILL_PIXELS  = video_pkg::H_ACTIVE;
    localparam logic [15:0] LFSR_SEED = 16'd98;
    // x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic                  clk_pixel;
    logic                  reset;
    pixel_pkg::fb_width_t  fb_width;
    pixel_pkg::fb_height_t fb_height;
    pixel_pkg::color_t     border_color;
    logic                  sleep;
    logic                  overlay_en;
    pixel_pkg::rgb_t       overlay_rgb;
    logic                  fill_start;
    logic [8:0]            fill_line;
    logic                  fill_we;
    pixel_pkg::color_t     fill_pixel;
    pixel_pkg::rgb_t       rgb;
    video_pkg::coord_t     out_x;
    video_pkg::coord_t     out_y;
    logic                  de;
    logic                  hsync;
    logic                  vsync;

    // Testbench state
    logic [15:0]       lfsr_state;
    row_t              active_row;
    // Copy of both banks
    pixel_pkg::color_t mirror [0:1][0:FILL_PIXELS-1];

    tb_clock i_clock (
        .clk_pixel (clk_pixel),
        .reset     (reset)
    );

    scan_doubler_480p i_dut (
        .clk_pixel    (clk_pixel),
        .reset        (reset),
        .fb_width     (fb_width),
        .fb_height    (fb_height),
        .border_color (border_color),
        .sleep        (sleep),
        .overlay_en   (overlay_en),
        .overlay_rgb  (overlay_rgb),
        .fill_start   (fill_start),
        .fill_line    (fill_line),
        .fill_we      (fill_we),
        .fill_pixel   (fill_pixel),
        .rgb          (rgb),
        .out_x        (out_x),
        .out_y        (out_y),
        .de           (de),
        .hsync        (hsync),
        .vsync        (vsync)
    );

    //////////////////////////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////////////////////////

    // Width, height, border, sleep, overlay_en, overlay_rgb and refill per row
    function automatic row_t row_setting(input int idx);
        row_t r;
        r = '0;
        case (idx)
            0: r = {10'd640, 9'd200, 18'h0F3C5, 1'b0, 1'b0, 24'h000000, 1'b0};
            // Size change moves both borders
            1: r = {10'd560, 9'd192, 18'h3F03F, 1'b0, 1'b0, 24'h000000, 1'b0};
            2: r = {10'd640, 9'd200, 18'h0F3C5, 1'b1, 1'b0, 24'h000000, 1'b0};
            // Overlay on top of sleep
            3: r = {10'd640, 9'd200, 18'h0F3C5, 1'b1, 1'b1, 24'hA5C381, 1'b0};
            // New data in bank 1 only
            4: r = {10'd640, 9'd200, 18'h2AAAA, 1'b0, 1'b0, 24'h000000, 1'b1};
            // Smallest picture with an odd top border
            default: r = {10'd4, 9'd1, 18'h15555, 1'b0, 1'b0, 24'h000000, 1'b0};
        endcase
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    function automatic int left_border(input row_t r);
        return (video_pkg::H_ACTIVE - int'(r.width)) / 2;
    endfunction

    function automatic int top_border(input row_t r);
        return (video_pkg::V_ACTIVE - 2 * int'(r.height)) / 2;
    endfunction

    function automatic logic in_picture(input int x, input int y, input row_t r);
        int left;
        int top;
        left = left_border(r);
        top  = top_border(r);
        return (x >= left) && (x < left + int'(r.width))
            && (y >= top) && (y < top + 2 * int'(r.height));
    endfunction

    // Channel by channel with zeros in the low bits
    function automatic pixel_pkg::rgb_t expand_color(input pixel_pkg::color_t c);
        int          cw;
        logic [23:0] wide;
        logic [23:0] mask;
        logic [7:0]  r;
        logic [7:0]  g;
        logic [7:0]  b;
        cw   = pixel_pkg::COLOR_BITS / 3;
        wide = 24'(c);
        mask = (24'd1 << cw) - 24'd1;
        r = 8'(((wide >> (2 * cw)) & mask) << (8 - cw));
        g = 8'(((wide >> cw) & mask) << (8 - cw));
        b = 8'((wide & mask) << (8 - cw));
        return {r, g, b};
    endfunction

    function automatic pixel_pkg::rgb_t dim_rgb(input pixel_pkg::rgb_t p);
        return {p[23:16] >> 1, p[15:8] >> 1, p[7:0] >> 1};
    endfunction

    function automatic pixel_pkg::rgb_t expected_rgb(input int x, input int y, input row_t r);
        pixel_pkg::rgb_t base;
        int              fb_line;
        // Blank outside the visible area
        if (x >= video_pkg::H_ACTIVE || y >= video_pkg::V_ACTIVE) begin
            return '0;
        end
        if (r.overlay_en) begin
            return r.overlay_rgb;
        end
        if (r.sleep) begin
            return '0;
        end
        if (in_picture(x, y, r)) begin
            // Both display lines of a framebuffer line read the same mirror line
            fb_line = (y - top_border(r)) / 2;
            base = expand_color(mirror[fb_line % 2][x - left_border(r)]);
        end else begin
            base = expand_color(r.border);
        end
        if (y % 2 == 1) begin
            base = dim_rgb(base);
        end
        return base;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Driving and checking
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic draw_pixel(output pixel_pkg::color_t p);
        p = '0;
        for (int i = 0; i < pixel_pkg::COLOR_BITS; i++) begin
            // Take the output bit, then step once
            p = {p[pixel_pkg::COLOR_BITS-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Bank follows the parity of the framebuffer line
    task automatic fill_bank(input int line);
        pixel_pkg::color_t p;
        @(negedge clk_pixel);
        fill_start = 1'b1;
        fill_line  = 9'(line);
        @(negedge clk_pixel);
        fill_start = 1'b0;
        for (int i = 0; i < FILL_PIXELS; i++) begin
            draw_pixel(p);
            fill_we    = 1'b1;
            fill_pixel = p;
            mirror[line % 2][i] = p;
            @(negedge clk_pixel);
        end
        fill_we = 1'b0;
    endtask

    task automatic wait_for_position(input int x, input int y, input string what);
        int waited;
        waited = 0;
        @(negedge clk_pixel);
        while (!(int'(out_x) == x && int'(out_y) == y) && waited < WAIT_LIMIT) begin
            @(negedge clk_pixel);
            waited++;
        end
        assert (int'(out_x) == x && int'(out_y) == y)
            else abort_run($sformatf("Timed out waiting for %s", what));
    endtask

    // Outputs must stay cleared while reset is held
    task automatic check_reset();
        int waited;
        waited = 0;
        @(negedge clk_pixel);
        while (reset && waited < RESET_LIMIT) begin
            assert (rgb == '0 && !de && !hsync && !vsync)
                else abort_run($sformatf("error at %0t: outputs not cleared in reset", $time));
            @(negedge clk_pixel);
            waited++;
        end
        assert (!reset) else abort_run("Reset was never released");
    endtask

    task automatic check_sample(input int x, input int y);
        logic            exp_de;
        logic            exp_hs;
        logic            exp_vs;
        pixel_pkg::rgb_t exp_rgb;
        exp_de  = (x < video_pkg::H_ACTIVE) && (y < video_pkg::V_ACTIVE);
        exp_hs  = (x >= video_pkg::H_SYNC_START) && (x < video_pkg::H_SYNC_END);
        exp_vs  = (y >= video_pkg::V_SYNC_START) && (y < video_pkg::V_SYNC_END);
        exp_rgb = expected_rgb(x, y, active_row);
        assert (int'(out_x) == x && int'(out_y) == y)
            else abort_run($sformatf("error at %0t: position (%0d, %0d), expected (%0d, %0d)",
                                     $time, out_x, out_y, x, y));
        assert (de == exp_de && hsync == exp_hs && vsync == exp_vs)
            else abort_run($sformatf("error at %0t: de/hsync/vsync %b%b%b at (%0d, %0d)",
                                     $time, de, hsync, vsync, x, y));
        assert (rgb == exp_rgb)
            else abort_run($sformatf("error at %0t: rgb %h at (%0d, %0d), expected %h",
                                     $time, rgb, x, y, exp_rgb));
    endtask

    // Starts on the sample of position (0, 0)
    task automatic check_frame();
        int x;
        int y;
        x = 0;
        y = 0;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            if (n > 0) begin
                @(negedge clk_pixel);
            end
            check_sample(x, y);
            if (x == video_pkg::H_TOTAL - 1) begin
                x = 0;
                y++;
            end else begin
                x++;
            end
        end
    endtask

    // Settings change in vertical blanking, then wait for the next frame
    task automatic apply_row(input row_t r);
        wait_for_position(0, video_pkg::V_ACTIVE, "vertical blanking");
        active_row   = r;
        fb_width     = r.width;
        fb_height    = r.height;
        border_color = r.border;
        sleep        = r.sleep;
        overlay_en   = r.overlay_en;
        overlay_rgb  = r.overlay_rgb;
        if (r.refill) begin
            fill_bank(7);
        end
        wait_for_position(0, 0, "the start of a frame");
    endtask

    initial begin
        fb_width     = 10'd640;
        fb_height    = 9'd200;
        border_color = '0;
        sleep        = 1'b0;
        overlay_en   = 1'b0;
        overlay_rgb  = '0;
        fill_start   = 1'b0;
        fill_line    = '0;
        fill_we      = 1'b0;
        fill_pixel   = '0;
        lfsr_state   = LFSR_SEED;
        active_row   = row_setting(0);
        check_reset();
        // First frame runs unchecked while both banks load
        fill_bank(0);
        fill_bank(1);
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(row_setting(r));
            check_frame();
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- scan_doubler_480p.f
source/video_pkg.sv
source/pixel_pkg.sv
source/line_fill.sv
source/line_buffer.sv
source/raster_timing.sv
source/active_window.sv
source/pixel_output.sv
source/scan_doubler_480p.sv
test/tb_clock.sv
test/tb_scan_doubler_480p.sv
